// ==== all.f ====
design/pcie_pkg.sv
design/link_status_led.sv
design/tlp_bar_demux.sv
design/mmio_bar_ram.sv
design/tlp_tx_arbiter.sv
design/pcie_mmio_top.sv
tb/clk_gen.sv
tb/mmio_chk.sv
tb/tb_top.sv

// ==== design/link_status_led.sv ====
`timescale 1ns/10ps

module link_status_led (
    input  logic       cfg_clk,
    input  logic       rstn,
    input  logic       pcie_linkup_i,
    output logic       tlp_rstn_o,
    output logic [3:0] led_o
);

    logic [pcie_pkg::PERST_BITS:0] perst_cnt;
    logic [pcie_pkg::START_BITS:0] start_cnt;
    logic [pcie_pkg::RUN_BIT:0]    run_cnt;
    logic                          linkup_q;
    logic                          perst_done;
    logic                          started;

    // Top bit of each counter is its done flag
    assign perst_done = perst_cnt[pcie_pkg::PERST_BITS];
    assign started    = start_cnt[pcie_pkg::START_BITS];

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            perst_cnt <= '0;
            start_cnt <= '0;
            run_cnt   <= '0;
            linkup_q  <= 1'b0;
        end else begin
            // Both delay counters stop once their flag bit sets
            if (!perst_done)
                perst_cnt <= perst_cnt + 1'b1;
            if (!started)
                start_cnt <= start_cnt + 1'b1;
            // Blink source, wraps freely
            run_cnt  <= run_cnt + 1'b1;
            // Link status into this clock domain
            linkup_q <= pcie_linkup_i;
        end
    end

    assign tlp_rstn_o = started;

    // LEDs are lit low
    assign led_o = {~linkup_q, ~started, ~perst_done, ~run_cnt[pcie_pkg::RUN_BIT]};

endmodule

// ==== design/mmio_bar_ram.sv ====
`timescale 1ns/10ps

module mmio_bar_ram #(
    parameter int AW = 4
) (
    input  logic               cfg_clk,
    input  logic               rstn,
    input  pcie_pkg::rx_beat_t beat_i,
    input  logic [12:0]        cfg_busdev_i,
    input  logic               cpl_grant_i,
    output logic               cpl_req_o,
    output pcie_pkg::cpl_t     cpl_o
);

    // Header DWs of the incoming beat
    logic [31:0]                                dw0;
    logic [31:0]                                dw1;
    logic [31:0]                                dw2;
    logic [31:0]                                dw3;
    logic                                       hdr_ok;
    logic                                       is_wr;
    logic                                       is_rd;
    // Decode stage
    logic                                       wr_q;
    logic                                       rd_q;
    logic [AW-1:0]                              addr_q;
    logic [31:0]                                wdata_q;
    logic [15:0]                                req_id_q;
    logic [7:0]                                 tag_q;
    logic [6:0]                                 low_addr_q;
    // Storage
    logic [31:0]                                ram [2**AW];
    pcie_pkg::cpl_t                             cpl_fifo [pcie_pkg::CPL_Q_DEPTH];
    pcie_pkg::cpl_t                             cpl_new;
    logic [$clog2(pcie_pkg::CPL_Q_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(pcie_pkg::CPL_Q_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(pcie_pkg::CPL_Q_DEPTH):0]     count;
    logic                                       full;
    logic                                       push;

    assign dw0 = beat_i.data[31:0];
    assign dw1 = beat_i.data[63:32];
    assign dw2 = beat_i.data[95:64];
    assign dw3 = beat_i.data[127:96];

    // Single-DW memory requests only
    assign hdr_ok = (|beat_i.valid) && (dw0[28:24] == pcie_pkg::TYP_MEM) &&
                    (dw0[9:0] == 10'd1);
    assign is_wr  = hdr_ok && (dw0[31:29] == pcie_pkg::FMT_MWR);
    assign is_rd  = hdr_ok && (dw0[31:29] == pcie_pkg::FMT_MRD);

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end else begin
            wr_q <= is_wr;
            rd_q <= is_rd;
        end
    end

    // Request fields, DW address starts at bit 2
    always_ff @(posedge cfg_clk) begin
        if (is_wr || is_rd) begin
            addr_q     <= dw2[AW+1:2];
            wdata_q    <= dw3;
            req_id_q   <= dw1[31:16];
            tag_q      <= dw1[15:8];
            low_addr_q <= {dw2[6:2], 2'b00};
        end
    end

    // Completion header, then the RAM word
    always_comb begin
        cpl_new.dw[0] = {pcie_pkg::FMT_CPLD, pcie_pkg::TYP_CPL, 14'd0, 10'd1};
        // Completer ID, status 0, byte count 4
        cpl_new.dw[1] = {cfg_busdev_i, 3'b000, 3'b000, 1'b0, 12'd4};
        cpl_new.dw[2] = {req_id_q, tag_q, 1'b0, low_addr_q};
        cpl_new.dw[3] = ram[addr_q];
    end

    // Reads beyond the queue depth are lost
    assign full = (count == pcie_pkg::CPL_Q_DEPTH);
    assign push = rd_q && !full;

    // RAM starts cleared so early reads return zero
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 2**AW; i++) begin
                ram[i] <= '0;
            end
        end else if (wr_q) begin
            ram[addr_q] <= wdata_q;
        end
    end

    always_ff @(posedge cfg_clk) begin
        if (push)
            cpl_fifo[wr_ptr] <= cpl_new;
    end

    // Queue pointers and fill level
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (cpl_grant_i)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, cpl_grant_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign cpl_req_o = (count != '0);
    assign cpl_o     = cpl_fifo[rd_ptr];

endmodule

// ==== design/pcie_mmio_top.sv ====
`timescale 1ns/10ps

module pcie_mmio_top (
    input  logic               cfg_clk,
    input  logic               rstn,
    input  pcie_pkg::rx_beat_t rx_i,
    input  logic [12:0]        cfg_busdev_i,
    input  logic               pcie_linkup_i,
    input  logic               tx_credit_i,
    output pcie_pkg::tx_beat_t tx_o,
    output logic [3:0]         led_o
);

    // TLP side held in reset until start
    logic                     tlp_rstn;
    // Steered RX beats
    pcie_pkg::rx_beat_t       bar1_beat;
    pcie_pkg::rx_beat_t       bar3_beat;
    // Completion handshake, index 0 is BAR1, index 1 is BAR3
    logic [1:0]               cpl_req;
    logic [1:0]               cpl_grant;
    pcie_pkg::cpl_t [1:0]     cpl;

    link_status_led u_link_status_led (
        .cfg_clk       (cfg_clk),
        .rstn          (rstn),
        .pcie_linkup_i (pcie_linkup_i),
        .tlp_rstn_o    (tlp_rstn),
        .led_o         (led_o)
    );

    tlp_bar_demux u_tlp_bar_demux (
        .cfg_clk (cfg_clk),
        .rstn    (tlp_rstn),
        .rx_i    (rx_i),
        .bar1_o  (bar1_beat),
        .bar3_o  (bar3_beat)
    );

    // Small MMIO window
    mmio_bar_ram #(
        .AW (pcie_pkg::BAR1_AW)
    ) u_bar1 (
        .cfg_clk      (cfg_clk),
        .rstn         (tlp_rstn),
        .beat_i       (bar1_beat),
        .cfg_busdev_i (cfg_busdev_i),
        .cpl_grant_i  (cpl_grant[0]),
        .cpl_req_o    (cpl_req[0]),
        .cpl_o        (cpl[0])
    );

    // Main MMIO test RAM
    mmio_bar_ram #(
        .AW (pcie_pkg::BAR3_AW)
    ) u_bar3 (
        .cfg_clk      (cfg_clk),
        .rstn         (tlp_rstn),
        .beat_i       (bar3_beat),
        .cfg_busdev_i (cfg_busdev_i),
        .cpl_grant_i  (cpl_grant[1]),
        .cpl_req_o    (cpl_req[1]),
        .cpl_o        (cpl[1])
    );

    tlp_tx_arbiter u_tlp_tx_arbiter (
        .cfg_clk       (cfg_clk),
        .rstn          (tlp_rstn),
        .pcie_linkup_i (pcie_linkup_i),
        .tx_credit_i   (tx_credit_i),
        .cpl_req_i     (cpl_req),
        .cpl_i         (cpl),
        .cpl_grant_o   (cpl_grant),
        .tx_o          (tx_o)
    );

endmodule

// ==== design/pcie_pkg.sv ====
package pcie_pkg;

    // Beat geometry
    localparam int DW_PER_BEAT = 4;
    localparam int BEAT_W      = 128;

    // Startup delays, as counter bit positions
    localparam int START_BITS = 8;
    localparam int PERST_BITS = 10;
    localparam int RUN_BIT    = 23;

    // Completion flow control
    localparam int CPL_CREDITS = 4;
    localparam int CPL_Q_DEPTH = 4;

    // BAR windows, DW address bits per RAM
    localparam int         BAR1_AW  = 4;
    localparam int         BAR3_AW  = 6;
    localparam logic [5:0] BAR1_HIT = 6'b000010;
    localparam logic [5:0] BAR3_HIT = 6'b001000;

    // Header fmt and type codes
    localparam logic [2:0] FMT_MWR  = 3'b010;
    localparam logic [2:0] FMT_MRD  = 3'b000;
    localparam logic [2:0] FMT_CPLD = 3'b010;
    localparam logic [4:0] TYP_MEM  = 5'b00000;
    localparam logic [4:0] TYP_CPL  = 5'b01010;

    // RX beat, DW0 sits in data[31:0]
    typedef struct packed {
        logic                   sop;
        logic                   eop;
        logic [DW_PER_BEAT-1:0] valid;
        logic [BEAT_W-1:0]      data;
        logic [5:0]             bardec;
    } rx_beat_t;

    // TX beat toward the link
    typedef struct packed {
        logic                   sop;
        logic                   eop;
        logic [DW_PER_BEAT-1:0] valid;
        logic [BEAT_W-1:0]      data;
    } tx_beat_t;

    // Completion with data, dw[0] is the first header DW
    typedef struct packed {
        logic [DW_PER_BEAT-1:0][31:0] dw;
    } cpl_t;

endpackage

// ==== design/tlp_bar_demux.sv ====
`timescale 1ns/10ps

module tlp_bar_demux (
    input  logic               cfg_clk,
    input  logic               rstn,
    input  pcie_pkg::rx_beat_t rx_i,
    output pcie_pkg::rx_beat_t bar1_o,
    output pcie_pkg::rx_beat_t bar3_o
);

    logic                                 single;
    logic                                 hit1;
    logic                                 hit3;
    logic [pcie_pkg::DW_PER_BEAT-1:0]     vld1_q;
    logic [pcie_pkg::DW_PER_BEAT-1:0]     vld3_q;
    logic [pcie_pkg::BEAT_W-1:0]          data_q;
    logic [5:0]                           bardec_q;

    // Only whole TLPs in one beat are kept
    assign single = rx_i.sop && rx_i.eop && (|rx_i.valid);
    assign hit1   = single && (rx_i.bardec == pcie_pkg::BAR1_HIT);
    assign hit3   = single && (rx_i.bardec == pcie_pkg::BAR3_HIT);

    // Per-BAR valid, BAR0 and unknown hits fall out here
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            vld1_q <= '0;
            vld3_q <= '0;
        end else begin
            vld1_q <= hit1 ? rx_i.valid : '0;
            vld3_q <= hit3 ? rx_i.valid : '0;
        end
    end

    // One payload register shared by both outputs
    always_ff @(posedge cfg_clk) begin
        if (single) begin
            data_q   <= rx_i.data;
            bardec_q <= rx_i.bardec;
        end
    end

    assign bar1_o = '{sop: |vld1_q, eop: |vld1_q, valid: vld1_q,
                      data: data_q, bardec: bardec_q};
    assign bar3_o = '{sop: |vld3_q, eop: |vld3_q, valid: vld3_q,
                      data: data_q, bardec: bardec_q};

endmodule

// ==== design/tlp_tx_arbiter.sv ====
`timescale 1ns/10ps

module tlp_tx_arbiter (
    input  logic                  cfg_clk,
    input  logic                  rstn,
    input  logic                  pcie_linkup_i,
    input  logic                  tx_credit_i,
    input  logic [1:0]            cpl_req_i,
    input  pcie_pkg::cpl_t [1:0]  cpl_i,
    output logic [1:0]            cpl_grant_o,
    output pcie_pkg::tx_beat_t    tx_o
);

    logic [$clog2(pcie_pkg::CPL_CREDITS+1)-1:0] credit_q;
    // Preferred source for the next grant
    logic                                       rr_q;
    logic                                       can_send;
    logic                                       gnt_any;
    logic                                       gnt_idx;
    logic                                       tx_vld_q;
    logic [pcie_pkg::BEAT_W-1:0]                tx_data_q;

    // Hold off on link down or credits exhausted
    assign can_send = pcie_linkup_i && (credit_q != '0);

    always_comb begin
        cpl_grant_o = '0;
        if (can_send) begin
            if (cpl_req_i[rr_q])
                cpl_grant_o[rr_q] = 1'b1;
            else if (cpl_req_i[~rr_q])
                cpl_grant_o[~rr_q] = 1'b1;
        end
    end

    assign gnt_any = |cpl_grant_o;
    assign gnt_idx = cpl_grant_o[1];

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            credit_q <= $bits(credit_q)'(pcie_pkg::CPL_CREDITS);
            rr_q     <= 1'b0;
            tx_vld_q <= 1'b0;
        end else begin
            // Grant and returned credit in one cycle cancel out
            case ({gnt_any, tx_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
            // Other source gets priority after a grant
            if (gnt_any)
                rr_q <= ~gnt_idx;
            tx_vld_q <= gnt_any;
        end
    end

    // Granted entry goes out next cycle
    always_ff @(posedge cfg_clk) begin
        if (gnt_any)
            tx_data_q <= cpl_i[gnt_idx];
    end

    // Completion fits in one beat, all DWs valid
    assign tx_o = '{sop: tx_vld_q, eop: tx_vld_q,
                    valid: {pcie_pkg::DW_PER_BEAT{tx_vld_q}}, data: tx_data_q};

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // Reset held low over the first two rising edges
    initial begin
        rstn_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

// ==== tb/mmio_chk.sv ====
`timescale 1ns/10ps

module mmio_chk (
    input logic                                          cfg_clk,
    input logic                                          rstn,
    input logic [1:0]                                    grant_i,
    input logic [$clog2(pcie_pkg::CPL_CREDITS+1)-1:0]    credit_i,
    input logic                                          tx_valid_i
);

    // Assertion failures so far
    int fail_cnt = 0;

    // One source at a time
    a_grant_onehot: assert property (@(posedge cfg_clk) disable iff (!rstn)
        $onehot0(grant_i))
        else begin
            fail_cnt++;
            $error("completion grant is not one-hot");
        end

    // Out of credits means no grant
    a_no_credit: assert property (@(posedge cfg_clk) disable iff (!rstn)
        (credit_i == '0) |-> (grant_i == '0))
        else begin
            fail_cnt++;
            $error("grant issued with zero credits");
        end

    // TX beat exactly one cycle behind its grant
    a_tx_after_grant: assert property (@(posedge cfg_clk) disable iff (!rstn)
        (|grant_i) |=> tx_valid_i)
        else begin
            fail_cnt++;
            $error("grant not followed by a TX beat");
        end

    a_tx_needs_grant: assert property (@(posedge cfg_clk) disable iff (!rstn)
        tx_valid_i |-> $past(|grant_i))
        else begin
            fail_cnt++;
            $error("TX beat without a grant the cycle before");
        end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;

    logic               cfg_clk;
    logic               rstn;
    pcie_pkg::rx_beat_t rx_i;
    logic [12:0]        cfg_busdev_i;
    logic               pcie_linkup_i;
    logic               tx_credit_i = 1'b0;
    pcie_pkg::tx_beat_t tx_o;
    logic [3:0]         led_o;

    // Reference RAMs and expected completions per BAR
    logic [31:0]  model1 [2**pcie_pkg::BAR1_AW];
    logic [31:0]  model3 [2**pcie_pkg::BAR3_AW];
    logic [127:0] exp1 [$];
    logic [127:0] exp3 [$];

    string    cur_test;
    int       errors;
    int       checks;
    int       tests;
    int       test_err0;
    int       sent;
    int       cycles;
    int       owed;
    bit       credit_run;
    bit [7:0] tag_n;

    clk_gen u_clk_gen (.clk_o(cfg_clk), .rstn_o(rstn));

    pcie_mmio_top dut_i (
        .cfg_clk       (cfg_clk),
        .rstn          (rstn),
        .rx_i          (rx_i),
        .cfg_busdev_i  (cfg_busdev_i),
        .pcie_linkup_i (pcie_linkup_i),
        .tx_credit_i   (tx_credit_i),
        .tx_o          (tx_o),
        .led_o         (led_o)
    );

    bind tlp_tx_arbiter mmio_chk u_mmio_chk (
        .cfg_clk    (cfg_clk),
        .rstn       (rstn),
        .grant_i    (cpl_grant_o),
        .credit_i   (credit_q),
        .tx_valid_i (|tx_o.valid)
    );

    // Requester ID tells the two BARs apart on TX
    function automatic logic [15:0] rid_of(int bar);
        return (bar == 1) ? 16'h0100 : 16'h0300;
    endfunction

    function automatic logic [5:0] hit_of(int bar);
        case (bar)
            1:       return pcie_pkg::BAR1_HIT;
            3:       return pcie_pkg::BAR3_HIT;
            default: return 6'b000001;
        endcase
    endfunction

    // Single-beat 3-DW request, write data in DW3
    function automatic pcie_pkg::rx_beat_t make_req(logic [2:0] fmt, logic [9:0] len, int bar,
                                                    logic [29:0] addr, logic [31:0] data);
        pcie_pkg::rx_beat_t b;
        b.sop    = 1'b1;
        b.eop    = 1'b1;
        b.valid  = (fmt == pcie_pkg::FMT_MWR) ? 4'b1111 : 4'b0111;
        b.data   = {data, addr, 2'b00, rid_of(bar), tag_n, 8'h00,
                    fmt, pcie_pkg::TYP_MEM, 14'd0, len};
        b.bardec = hit_of(bar);
        return b;
    endfunction

    // Expected CplD, header per the completion layout, then the word
    function automatic logic [127:0] ref_cpl(logic [15:0] rid, logic [7:0] tag,
                                             logic [29:0] addr, logic [31:0] word);
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] d2;
        // Length of one DW
        d0        = 32'd1;
        d0[31:29] = pcie_pkg::FMT_CPLD;
        d0[28:24] = pcie_pkg::TYP_CPL;
        // Completer ID in the upper half, status 0 and byte count 4 below
        d1 = {(16'(cfg_busdev_i) << 3), 16'd4};
        // Lower address, byte address bits 6:0
        d2 = {rid, tag, 1'b0, addr[4:0], 2'b00};
        return {word, d2, d1, d0};
    endfunction

    task automatic check(string what, logic [127:0] exp, logic [127:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s %s expected %0h actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic send(pcie_pkg::rx_beat_t b);
        @(posedge cfg_clk);
        rx_i <= b;
        @(posedge cfg_clk);
        rx_i <= '0;
        tag_n++;
    endtask

    task automatic write_bar(int bar, logic [29:0] addr, logic [31:0] data);
        send(make_req(pcie_pkg::FMT_MWR, 10'd1, bar, addr, data));
        // Upper address bits wrap inside each window
        if (bar == 1)
            model1[addr[pcie_pkg::BAR1_AW-1:0]] = data;
        else if (bar == 3)
            model3[addr[pcie_pkg::BAR3_AW-1:0]] = data;
    endtask

    task automatic read_bar(int bar, logic [29:0] addr, logic [9:0] len);
        logic [127:0] e;
        if (bar == 1)
            e = ref_cpl(rid_of(1), tag_n, addr, model1[addr[pcie_pkg::BAR1_AW-1:0]]);
        else
            e = ref_cpl(rid_of(3), tag_n, addr, model3[addr[pcie_pkg::BAR3_AW-1:0]]);
        // Only single-DW reads to BAR1 or BAR3 are answered
        if (len == 10'd1 && bar == 1)
            exp1.push_back(e);
        if (len == 10'd1 && bar == 3)
            exp3.push_back(e);
        send(make_req(pcie_pkg::FMT_MRD, len, bar, addr, 32'h0));
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge cfg_clk);
    endtask

    // Until every expected completion arrived, then some quiet cycles
    task automatic drain();
        while (exp1.size() != 0 || exp3.size() != 0)
            @(negedge cfg_clk);
        idle(8);
    endtask

    task automatic start_test(string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %-10s %s, %0d errors", cur_test,
                 (errors == test_err0) ? "ok" : "FAILED", errors - test_err0);
    endtask

    // Each TX beat against the head of its BAR queue
    always @(posedge cfg_clk) begin : compare
        logic [15:0] rid;
        if (tx_o.valid != '0) begin
            sent++;
            rid = tx_o.data[95:80];
            check("framing", 6'h3f, {tx_o.sop, tx_o.eop, tx_o.valid});
            checks++;
            assert ((rid == rid_of(1) && exp1.size() != 0) ||
                    (rid == rid_of(3) && exp3.size() != 0)) else begin
                errors++;
                $display("%s: completion for requester %h arrived with none outstanding",
                         cur_test, rid);
            end
            if (rid == rid_of(1) && exp1.size() != 0)
                check("bar1 cpl", exp1.pop_front(), tx_o.data);
            else if (rid == rid_of(3) && exp3.size() != 0)
                check("bar3 cpl", exp3.pop_front(), tx_o.data);
        end
    end

    // One credit back per cycle for each beat, held off while credit_run is low
    always @(posedge cfg_clk) begin : credit_return
        if (tx_o.valid != '0)
            owed++;
        if (credit_run && owed > 0) begin
            owed--;
            tx_credit_i <= 1'b1;
        end else begin
            tx_credit_i <= 1'b0;
        end
    end

    // Startup takes about 1030 cycles, the tests well under 1000
    always @(posedge cfg_clk) begin : watchdog
        cycles++;
        if (cycles >= 4000) begin
            $display("Timeout after %0d cycles, completions stopped arriving", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin : main
        pcie_pkg::rx_beat_t b;
        logic [29:0]        addrs [8];
        logic [31:0]        d;
        int                 t0;
        int                 base;
        void'($urandom(32'h21d6));
        rx_i          = '0;
        pcie_linkup_i = 1'b1;
        cfg_busdev_i  = 13'($urandom);
        credit_run    = 1'b1;
        foreach (model1[i])
            model1[i] = '0;
        foreach (model3[i])
            model3[i] = '0;
        wait (rstn === 1'b1);
        t0 = cycles;

        start_test("startup");
        @(negedge cfg_clk);
        check("led after reset", 3'b111, led_o[2:0]);
        // TLP side still in reset here, write must vanish
        send(make_req(pcie_pkg::FMT_MWR, 10'd1, 3, 30'd5, $urandom));
        @(negedge cfg_clk);
        check("led3 link", !pcie_linkup_i, led_o[3]);
        while (led_o[2])
            @(negedge cfg_clk);
        check("start delay", 2**pcie_pkg::START_BITS, cycles - t0);
        // PERST LED comes on well after start
        while (led_o[1])
            @(negedge cfg_clk);
        check("perst delay", 2**pcie_pkg::PERST_BITS, cycles - t0);
        idle(2);
        read_bar(3, 30'd5, 10'd1);
        drain();
        end_test();

        start_test("bar3_rw");
        foreach (addrs[i]) begin
            addrs[i] = 30'($urandom);
            write_bar(3, addrs[i], $urandom);
        end
        foreach (addrs[i])
            read_bar(3, addrs[i], 10'd1);
        drain();
        end_test();

        start_test("bar_indep");
        d = $urandom;
        write_bar(1, 30'd3, d);
        write_bar(3, 30'd3, ~d);
        // DW address 23 lands on BAR1 word 7
        write_bar(1, 30'd23, $urandom);
        read_bar(1, 30'd3, 10'd1);
        read_bar(3, 30'd3, 10'd1);
        read_bar(1, 30'd7, 10'd1);
        read_bar(1, 30'd23, 10'd1);
        drain();
        end_test();

        start_test("credits");
        credit_run = 1'b0;
        base       = sent;
        for (int i = 0; i < 3; i++) begin
            read_bar(1, 30'(i), 10'd1);
            read_bar(3, 30'(i), 10'd1);
        end
        while (sent < base + pcie_pkg::CPL_CREDITS)
            @(negedge cfg_clk);
        idle(20);
        check("sent without credit", base + pcie_pkg::CPL_CREDITS, sent);
        credit_run = 1'b1;
        drain();
        // Link down holds the queue
        @(posedge cfg_clk);
        pcie_linkup_i <= 1'b0;
        base = sent;
        read_bar(3, 30'd9, 10'd1);
        idle(20);
        check("sent with link down", base, sent);
        check("led3 link down", 1'b1, led_o[3]);
        @(posedge cfg_clk);
        pcie_linkup_i <= 1'b1;
        drain();
        end_test();

        start_test("discard");
        write_bar(0, 30'd2, $urandom);
        // Same write split over two beats
        b     = make_req(pcie_pkg::FMT_MWR, 10'd1, 3, 30'd2, $urandom);
        b.eop = 1'b0;
        send(b);
        b.sop = 1'b0;
        b.eop = 1'b1;
        send(b);
        read_bar(3, 30'd2, 10'd2);
        read_bar(3, 30'd2, 10'd1);
        read_bar(1, 30'd2, 10'd1);
        drain();
        end_test();

        errors += dut_i.u_tlp_tx_arbiter.u_mmio_chk.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
